// File: glb_params.svh
`ifndef GLB_PARAMS_SVH
`define GLB_PARAMS_SVH

// number of memory tiles in the ring
`define GLB_NUM_TILES 4

// bits needed to name one tile
`define GLB_TILE_SEL_WIDTH 2

// word address inside one bank
// 64 words per tile
`define GLB_BANK_ADDR_WIDTH 6

// width of one stored word
`define GLB_DATA_WIDTH 16

`endif

// File: glb_types_pkg.sv
`include "glb_params.svh"

package glb_types_pkg;

    // tile number inside the ring
    typedef logic [`GLB_TILE_SEL_WIDTH-1:0] tile_id_t;

    // word address within one bank
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // flat host address
    // tile number on top, bank address below
    typedef logic [`GLB_TILE_SEL_WIDTH+`GLB_BANK_ADDR_WIDTH-1:0] glb_addr_t;

    // one data word
    typedef logic [`GLB_DATA_WIDTH-1:0] data_t;

endpackage

// File: glb_packet_pkg.sv
package glb_packet_pkg;

    // packet opcode carried on the ring
    typedef logic [1:0] packet_op_t;

    // slot holds nothing useful
    localparam packet_op_t PKT_NOP = 2'd0;

    // write request, stays a write after the bank is updated
    localparam packet_op_t PKT_WRITE = 2'd1;

    // read request, not yet served
    localparam packet_op_t PKT_READ = 2'd2;

    // served read, data field holds the bank word
    localparam packet_op_t PKT_RDRESP = 2'd3;

endpackage

// File: glb_packet_if.sv
`timescale 1ns/1ps

// one stream packet on a single hop
interface glb_packet_if
    import glb_types_pkg::*, glb_packet_pkg::*;
();

    // slot occupied
    logic valid;

    // request or response kind
    packet_op_t op;

    // target tile
    tile_id_t tile;

    // word inside the target bank
    bank_addr_t addr;

    // write data or read result
    data_t data;

    // driving side of the hop
    modport src (
        output valid,
        output op,
        output tile,
        output addr,
        output data
    );

    // receiving side of the hop
    modport snk (
        input valid,
        input op,
        input tile,
        input addr,
        input data
    );

endinterface

// File: glb_packet_decoder.sv
`timescale 1ns/1ps

module glb_packet_decoder
    import glb_types_pkg::*, glb_packet_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      clk_en,
    input  logic      req_valid,
    input  logic      req_write,
    input  glb_addr_t req_addr,
    input  data_t     req_wdata,
    glb_packet_if.src inj
);

    // address split into its two fields
    tile_id_t   req_tile;
    bank_addr_t req_bank;
    packet_op_t req_op;

    assign {req_tile, req_bank} = req_addr;

    // no request gives an empty slot
    assign req_op = !req_valid ? PKT_NOP
                  : req_write  ? PKT_WRITE
                  :              PKT_READ;

    // slot valid bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            inj.valid <= 1'b0;
        end else if (clk_en) begin
            inj.valid <= req_valid;
        end
    end

    // packet body
    // only meaningful while valid is high
    always_ff @(posedge clk) begin
        if (clk_en) begin
            inj.op   <= req_op;
            inj.tile <= req_tile;
            inj.addr <= req_bank;
            inj.data <= req_wdata;
        end
    end

endmodule

// File: glb_bank_switch.sv
`timescale 1ns/1ps
`include "glb_params.svh"

module glb_bank_switch
    import glb_types_pkg::*, glb_packet_pkg::*;
#(
    parameter int tile_id = 0
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      clk_en,
    glb_packet_if.snk pkt_in,
    glb_packet_if.src sw2sr
);

    localparam int bank_depth = 2 ** `GLB_BANK_ADDR_WIDTH;

    // this tile's storage
    data_t bank_mem [bank_depth];

    logic  hit;
    logic  wr_hit;
    logic  rd_hit;
    data_t rd_word;

    // packet addressed to this tile
    assign hit = pkt_in.valid && (pkt_in.tile == tile_id_t'(tile_id));

    // served writes keep PKT_WRITE and responses never match a request op
    // so each packet is acted on at most once
    assign wr_hit = hit && (pkt_in.op == PKT_WRITE);
    assign rd_hit = hit && (pkt_in.op == PKT_READ);

    // async bank read
    assign rd_word = bank_mem[pkt_in.addr];

    // bank write on the same edge the packet is registered
    always_ff @(posedge clk) begin
        if (clk_en && wr_hit) begin
            bank_mem[pkt_in.addr] <= pkt_in.data;
        end
    end

    // output slot valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sw2sr.valid <= 1'b0;
        end else if (clk_en) begin
            sw2sr.valid <= pkt_in.valid;
        end
    end

    // output body
    // a read hit turns into a response with the stored word
    // everything else passes unchanged
    always_ff @(posedge clk) begin
        if (clk_en) begin
            sw2sr.tile <= pkt_in.tile;
            sw2sr.addr <= pkt_in.addr;
            if (rd_hit) begin
                sw2sr.op   <= PKT_RDRESP;
                sw2sr.data <= rd_word;
            end else begin
                sw2sr.op   <= pkt_in.op;
                sw2sr.data <= pkt_in.data;
            end
        end
    end

endmodule

// File: glb_core_strm_router.sv
`timescale 1ns/1ps
`include "glb_params.svh"

module glb_core_strm_router
    import glb_types_pkg::*, glb_packet_pkg::*;
#(
    parameter int tile_id = 0
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      clk_en,
    glb_packet_if.snk w2e_wsti,
    glb_packet_if.src e2w_wsto,
    glb_packet_if.snk e2w_esti,
    glb_packet_if.src w2e_esto,
    glb_packet_if.snk sw2sr,
    glb_packet_if.src sr2sw
);

    // tile position in the chain
    // tile 0 counts as even
    localparam bit is_even  = (tile_id % 2) == 0;
    localparam bit has_west = tile_id > 0;
    localparam bit has_east = tile_id < (`GLB_NUM_TILES - 1);

    // flattened packet width, valid bit on top
    localparam int payload_w = $bits(packet_op_t) + $bits(tile_id_t)
                             + $bits(bank_addr_t) + $bits(data_t);
    localparam int pkt_w = 1 + payload_w;

    logic [pkt_w-1:0]     w_turned;
    logic [pkt_w-1:0]     e_turned;
    logic [pkt_w-1:0]     east_int;
    logic [pkt_w-1:0]     west_int;
    logic [pkt_w-1:0]     core_d1;
    logic [pkt_w-1:0]     sr2sw_int;
    logic                 core_valid_d1;
    logic [payload_w-1:0] core_payload_d1;

    // west side input
    // first tile loops its own westbound stream back east
    if (has_west) begin : g_west_link
        assign w_turned = {w2e_wsti.valid, w2e_wsti.op, w2e_wsti.tile,
                           w2e_wsti.addr, w2e_wsti.data};
    end else begin : g_west_turn
        assign w_turned = west_int;
    end

    // east side input
    // last tile loops its own eastbound stream back west
    if (has_east) begin : g_east_link
        assign e_turned = {e2w_esti.valid, e2w_esti.op, e2w_esti.tile,
                           e2w_esti.addr, e2w_esti.data};
    end else begin : g_east_turn
        assign e_turned = east_int;
    end

    // core to router pipeline stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            core_valid_d1 <= 1'b0;
        end else if (clk_en) begin
            core_valid_d1 <= sw2sr.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            core_payload_d1 <= {sw2sr.op, sw2sr.tile, sw2sr.addr, sw2sr.data};
        end
    end

    assign core_d1 = {core_valid_d1, core_payload_d1};

    // even tiles serve the eastbound leg, odd tiles the westbound leg
    // the other direction goes straight through
    assign sr2sw_int = is_even ? w_turned : e_turned;
    assign east_int  = is_even ? core_d1  : w_turned;
    assign west_int  = is_even ? e_turned : core_d1;

    // unpack onto the outgoing hops
    assign {w2e_esto.valid, w2e_esto.op, w2e_esto.tile,
            w2e_esto.addr, w2e_esto.data} = east_int;
    assign {e2w_wsto.valid, e2w_wsto.op, e2w_wsto.tile,
            e2w_wsto.addr, e2w_wsto.data} = west_int;
    assign {sr2sw.valid, sr2sw.op, sr2sw.tile,
            sr2sw.addr, sr2sw.data} = sr2sw_int;

endmodule

// File: glb_response_collector.sv
`timescale 1ns/1ps

module glb_response_collector
    import glb_types_pkg::*, glb_packet_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      clk_en,
    glb_packet_if.snk ring_out,
    output logic      wr_ack,
    output logic      resp_valid,
    output glb_addr_t resp_addr,
    output data_t     resp_data
);

    logic wr_done;
    logic rd_done;

    // finished packets back at tile 0
    assign wr_done = ring_out.valid && (ring_out.op == PKT_WRITE);
    assign rd_done = ring_out.valid && (ring_out.op == PKT_RDRESP);

    // one pulse per returning packet
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ack     <= 1'b0;
            resp_valid <= 1'b0;
        end else if (clk_en) begin
            wr_ack     <= wr_done;
            resp_valid <= rd_done;
        end
    end

    // read result, flat address rebuilt from the two fields
    always_ff @(posedge clk) begin
        if (clk_en && rd_done) begin
            resp_addr <= {ring_out.tile, ring_out.addr};
            resp_data <= ring_out.data;
        end
    end

endmodule

// File: glb_top.sv
`timescale 1ns/1ps
`include "glb_params.svh"

module glb_top
    import glb_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      clk_en,
    input  logic      req_valid,
    input  logic      req_write,
    input  glb_addr_t req_addr,
    input  data_t     req_wdata,
    output logic      wr_ack,
    output logic      resp_valid,
    output glb_addr_t resp_addr,
    output data_t     resp_data
);

    // decoder into tile 0
    glb_packet_if inj_if ();

    // per tile core links
    glb_packet_if sw2sr_if [`GLB_NUM_TILES] ();
    glb_packet_if sr2sw_if [`GLB_NUM_TILES] ();

    // ring hops
    // index k enters or leaves tile k on its west side
    // outer boundary entries stay unused
    glb_packet_if w2e_if [`GLB_NUM_TILES+1] ();
    glb_packet_if e2w_if [`GLB_NUM_TILES+1] ();

    glb_packet_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .clk_en    (clk_en),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .inj       (inj_if)
    );

    for (genvar k = 0; k < `GLB_NUM_TILES; k++) begin : g_tile
        // tile 0 takes new packets, its router output leaves the ring
        if (k == 0) begin : g_head
            glb_bank_switch #(.tile_id(k)) u_switch (
                .clk    (clk),
                .reset  (reset),
                .clk_en (clk_en),
                .pkt_in (inj_if),
                .sw2sr  (sw2sr_if[k])
            );
        end else begin : g_body
            glb_bank_switch #(.tile_id(k)) u_switch (
                .clk    (clk),
                .reset  (reset),
                .clk_en (clk_en),
                .pkt_in (sr2sw_if[k]),
                .sw2sr  (sw2sr_if[k])
            );
        end

        glb_core_strm_router #(.tile_id(k)) u_router (
            .clk      (clk),
            .reset    (reset),
            .clk_en   (clk_en),
            .w2e_wsti (w2e_if[k]),
            .e2w_wsto (e2w_if[k]),
            .e2w_esti (e2w_if[k+1]),
            .w2e_esto (w2e_if[k+1]),
            .sw2sr    (sw2sr_if[k]),
            .sr2sw    (sr2sw_if[k])
        );
    end

    glb_response_collector u_collector (
        .clk        (clk),
        .reset      (reset),
        .clk_en     (clk_en),
        .ring_out   (sr2sw_if[0]),
        .wr_ack     (wr_ack),
        .resp_valid (resp_valid),
        .resp_addr  (resp_addr),
        .resp_data  (resp_data)
    );

endmodule

// File: glb_top_asserts.sv
`timescale 1ns/1ps

// protocol checks on the host side outputs
module glb_top_asserts (
    input logic clk,
    input logic reset,
    input logic clk_en,
    input logic wr_ack,
    input logic resp_valid
);

    // one result kind per cycle
    a_one_result: assert property (
        @(posedge clk) disable iff (reset) !(wr_ack && resp_valid)
    ) else $error("wr_ack and resp_valid high together");

    // pulses held low through reset
    a_reset_quiet: assert property (
        @(posedge clk) reset |-> (!wr_ack && !resp_valid)
    ) else $error("result output high during reset");

    // a new pulse needs an enabled edge before it
    a_ack_frozen: assert property (
        @(posedge clk) disable iff (reset) $rose(wr_ack) |-> $past(clk_en)
    ) else $error("wr_ack rose while clk_en was low");

    a_resp_frozen: assert property (
        @(posedge clk) disable iff (reset) $rose(resp_valid) |-> $past(clk_en)
    ) else $error("resp_valid rose while clk_en was low");

endmodule

bind glb_top glb_top_asserts u_asserts (
    .clk        (clk),
    .reset      (reset),
    .clk_en     (clk_en),
    .wr_ack     (wr_ack),
    .resp_valid (resp_valid)
);

// File: tb_glb_top.sv
`timescale 1ns/1ps
`include "glb_params.svh"

module tb_glb_top
    import glb_types_pkg::*;
();

    // rough sum of all tests with their drains is about 400 cycles
    localparam int test_cycles = 400;
    localparam int cycle_limit = 10 * test_cycles;
    localparam int burst_len   = 24;
    localparam int addr_space  = 2 ** (`GLB_TILE_SEL_WIDTH + `GLB_BANK_ADDR_WIDTH);

    logic      clk;
    logic      reset;
    logic      clk_en;
    logic      req_valid;
    logic      req_write;
    glb_addr_t req_addr;
    data_t     req_wdata;
    logic      wr_ack;
    logic      resp_valid;
    glb_addr_t resp_addr;
    data_t     resp_data;

    // reference memory over the flat address space
    data_t ref_mem [addr_space];

    // outstanding results in request order
    logic      exp_write [$];
    glb_addr_t exp_addr [$];
    data_t     exp_data [$];

    int          cycle_count = 0;
    int unsigned seed_ret;

    glb_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .clk_en     (clk_en),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .wr_ack     (wr_ack),
        .resp_valid (resp_valid),
        .resp_addr  (resp_addr),
        .resp_data  (resp_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // hard stop if the ring never drains
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    // registered outputs are settled by the falling edge
    always @(negedge clk) begin : result_monitor
        logic      exp_w;
        glb_addr_t exp_a;
        data_t     exp_d;
        if (reset) begin
            if (wr_ack || resp_valid) begin
                stop_with_failure("result output high during reset");
            end
        end else if (wr_ack && resp_valid) begin
            stop_with_failure("wr_ack and resp_valid high in the same cycle");
        end else if (wr_ack || resp_valid) begin
            if (exp_write.size() == 0) begin
                stop_with_failure("result appeared with no request outstanding");
            end else begin
                exp_w = exp_write.pop_front();
                exp_a = exp_addr.pop_front();
                exp_d = exp_data.pop_front();
                check_value("wr_ack", 32'(wr_ack), 32'(exp_w));
                check_value("resp_valid", 32'(resp_valid), 32'(!exp_w));
                // reads only carry address and data
                if (!exp_w) begin
                    check_value("resp_addr", 32'(resp_addr), 32'(exp_a));
                    check_value("resp_data", 32'(resp_data), 32'(exp_d));
                end
            end
        end
    end

    // expected result is queued when the request is driven
    task automatic issue_request(input logic is_write, input glb_addr_t addr, input data_t wdata);
        req_valid = 1'b1;
        req_write = is_write;
        req_addr  = addr;
        req_wdata = wdata;
        exp_write.push_back(is_write);
        exp_addr.push_back(addr);
        if (is_write) begin
            ref_mem[addr] = wdata;
        end
        exp_data.push_back(ref_mem[addr]);
        @(negedge clk);
    endtask

    task automatic release_bus;
        req_valid = 1'b0;
        req_write = 1'b0;
    endtask

    // wait for every result and a few idle cycles for strays
    task automatic wait_drain;
        while (exp_write.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic check_outputs_quiet;
        check_value("wr_ack", 32'(wr_ack), 32'd0);
        check_value("resp_valid", 32'(resp_valid), 32'd0);
    endtask

    task automatic idle_after_reset;
        repeat (20) begin
            check_outputs_quiet();
            @(negedge clk);
        end
    endtask

    // one address per tile covers even, odd and both end tiles
    task automatic write_read_each_tile;
        glb_addr_t addr [`GLB_NUM_TILES];
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            addr[t] = {tile_id_t'(t), bank_addr_t'(3 + 17 * t)};
            issue_request(1'b1, addr[t], data_t'($urandom));
        end
        release_bus();
        wait_drain();
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            issue_request(1'b0, addr[t], '0);
        end
        release_bus();
        wait_drain();
    endtask

    task automatic random_burst;
        glb_addr_t addr [burst_len];
        for (int i = 0; i < burst_len; i++) begin
            addr[i] = glb_addr_t'($urandom);
            issue_request(1'b1, addr[i], data_t'($urandom));
        end
        // reads follow the last write with no gap
        for (int i = 0; i < burst_len; i++) begin
            issue_request(1'b0, addr[i], '0);
        end
        release_bus();
        wait_drain();
    endtask

    // read right behind a write to the same word
    task automatic write_then_read_adjacent;
        glb_addr_t addr;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            addr = {tile_id_t'(t), bank_addr_t'($urandom)};
            issue_request(1'b1, addr, data_t'($urandom));
            issue_request(1'b0, addr, '0);
            release_bus();
            wait_drain();
        end
    endtask

    // each tile keeps its own word at a shared bank offset
    task automatic same_offset_per_tile;
        bank_addr_t offset;
        offset = bank_addr_t'($urandom);
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            issue_request(1'b1, {tile_id_t'(t), offset}, data_t'({4'(t), 12'($urandom)}));
        end
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            issue_request(1'b0, {tile_id_t'(t), offset}, '0);
        end
        release_bus();
        wait_drain();
    endtask

    task automatic clock_enable_freeze;
        glb_addr_t addr [`GLB_NUM_TILES];
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            addr[t] = {tile_id_t'(t), bank_addr_t'($urandom)};
            issue_request(1'b1, addr[t], data_t'($urandom));
        end
        release_bus();
        wait_drain();
        // ring is empty here
        clk_en = 1'b0;
        for (int i = 0; i < 8; i++) begin
            req_valid = 1'b1;
            req_write = (i % 2) == 0;
            req_addr  = addr[i % `GLB_NUM_TILES];
            req_wdata = ~ref_mem[req_addr];
            @(negedge clk);
            check_outputs_quiet();
        end
        release_bus();
        @(negedge clk);
        clk_en = 1'b1;
        repeat (12) begin
            @(negedge clk);
            check_outputs_quiet();
        end
        // frozen requests must have left the banks alone
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            issue_request(1'b0, addr[t], '0);
        end
        release_bus();
        wait_drain();
    endtask

    initial begin
        seed_ret  = $urandom(74287);
        reset     = 1'b1;
        clk_en    = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        idle_after_reset();
        write_read_each_tile();
        random_burst();
        write_then_read_adjacent();
        same_offset_per_tile();
        clock_enable_freeze();

        if (exp_write.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("%0d results never arrived", exp_write.size());
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

endmodule

// File: all.f
+incdir+.
glb_types_pkg.sv
glb_packet_pkg.sv
glb_packet_if.sv
glb_packet_decoder.sv
glb_bank_switch.sv
glb_core_strm_router.sv
glb_response_collector.sv
glb_top.sv
glb_top_asserts.sv
tb_glb_top.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_glb_top \
    -o tb_glb_top

./obj_dir/tb_glb_top
